/* Bender.yml */
package:
  name: rv_core

sources:
  - rv_core_pkg.sv
  - inst_queue.sv
  - id_stage.sv
  - reg_file.sv
  - csr_file.sv
  - ex_stage.sv
  - rv_core_top.sv
  - target: test
    files:
      - rv_core_assert.sv
      - tb_rv_core.sv

/* build.f */
rv_core_pkg.sv
inst_queue.sv
id_stage.sv
reg_file.sv
csr_file.sv
ex_stage.sv
rv_core_top.sv
rv_core_assert.sv
tb_rv_core.sv

/* csr_file.sv */
/*
 * machine CSRs mstatus, mtvec, mscratch and mepc,
 * one read port with write-through
 */
`default_nettype none

module csr_file
  import rv_core_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic [11:0]     csr_addr,
  output logic [XLEN-1:0] csr_data,
  input  csr_wr_t         wr
);

  logic [XLEN-1:0] csr_q [4];
  logic [2:0]      rd_slot;
  logic [2:0]      wr_slot;

  // {hit, index}, unknown addresses miss
  function automatic logic [2:0] slot_of(input logic [11:0] addr);
    case (addr)
      CSR_MSTATUS:  return 3'b100;
      CSR_MTVEC:    return 3'b101;
      CSR_MSCRATCH: return 3'b110;
      CSR_MEPC:     return 3'b111;
      default:      return 3'b000;
    endcase
  endfunction

  assign rd_slot = slot_of(csr_addr);
  assign wr_slot = slot_of(wr.addr);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 4; i++) begin
        csr_q[i] <= '0;
      end
    end else if (wr.ena && wr_slot[2]) begin
      csr_q[wr_slot[1:0]] <= wr.data;
    end
  end

  always_comb begin
    if (!rd_slot[2]) begin
      csr_data = '0;
    end else if (wr.ena && (wr.addr == csr_addr)) begin
      csr_data = wr.data;
    end else begin
      csr_data = csr_q[rd_slot[1:0]];
    end
  end

endmodule

`default_nettype wire

/* ex_stage.sv */
/*
 * execute stage: decode register, ALU, branch resolution,
 * writeback to the register and CSR files, retire record
 */
`default_nettype none

module ex_stage
  import rv_core_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  dec_t    dec,
  output reg_wr_t reg_wr,
  output csr_wr_t csr_wr,
  output logic    retire_valid,
  output retire_t retire
);

  dec_t            dec_q;
  alu_info_t       alu;
  bj_info_t        bj;
  logic [5:0]      shamt;
  logic [XLEN-1:0] sra_src;
  logic [XLEN-1:0] alu_raw;
  logic [XLEN-1:0] alu_out;
  logic            eq;
  logic            lt;
  logic            ltu;
  logic            taken;
  logic [XLEN-1:0] jalr_sum;
  logic [XLEN-1:0] target;
  logic [XLEN-1:0] link;
  logic [XLEN-1:0] rd_data;
  logic [XLEN-1:0] result;

  always_ff @(posedge clk) begin
    dec_q <= dec;
    if (reset) begin
      dec_q.valid <= 1'b0;
    end
  end

  assign alu = dec_q.alu_info;
  assign bj  = dec_q.bj_info;

  // word shifts take 5 bits of amount and shift in bit 31
  assign shamt   = dec_q.is_word ? {1'b0, dec_q.op2[4:0]} : dec_q.op2[5:0];
  assign sra_src = dec_q.is_word ? {{(XLEN-32){dec_q.op1[31]}}, dec_q.op1[31:0]}
                                 : dec_q.op1;

  always_comb begin
    alu_raw = '0;
    case (1'b1)
      alu.add:  alu_raw = dec_q.op1 + dec_q.op2;
      alu.sub:  alu_raw = dec_q.op1 - dec_q.op2;
      alu.slt:  alu_raw = XLEN'($signed(dec_q.op1) < $signed(dec_q.op2));
      alu.sltu: alu_raw = XLEN'(dec_q.op1 < dec_q.op2);
      alu.bxor: alu_raw = dec_q.op1 ^ dec_q.op2;
      alu.bor:  alu_raw = dec_q.op1 | dec_q.op2;
      alu.band: alu_raw = dec_q.op1 & dec_q.op2;
      alu.sll:  alu_raw = dec_q.op1 << shamt;
      alu.srl:  alu_raw = dec_q.op1 >> shamt;
      alu.sra:  alu_raw = $signed(sra_src) >>> shamt;
      alu.andn: alu_raw = dec_q.op1 & ~dec_q.op2;
      alu.wri:  alu_raw = dec_q.op2;
      default: ;
    endcase
  end

  assign alu_out = dec_q.is_word ? {{(XLEN-32){alu_raw[31]}}, alu_raw[31:0]} : alu_raw;

  // branch compare
  assign eq  = (dec_q.op1 == dec_q.op2);
  assign lt  = ($signed(dec_q.op1) < $signed(dec_q.op2));
  assign ltu = (dec_q.op1 < dec_q.op2);

  assign taken = (bj.beq & eq) | (bj.bne & ~eq) | (bj.blt & lt) | (bj.bge & ~lt)
               | (bj.bltu & ltu) | (bj.bgeu & ~ltu) | bj.jal | bj.jalr;

  assign jalr_sum = dec_q.op1 + dec_q.jmp_imm;
  assign target   = bj.jalr ? {jalr_sum[XLEN-1:1], 1'b0} : dec_q.pc + dec_q.jmp_imm;
  assign link     = dec_q.pc + XLEN'(4);

  // csr ops return the old value, the ALU result goes back to the CSR
  assign rd_data = dec_q.wb_sel.pc_to_reg  ? link :
                   dec_q.wb_sel.csr_to_reg ? dec_q.csr_old : alu_out;

  assign result = dec_q.wb_sel.mem_addr ? alu_out :
                  dec_q.rd_w_ena        ? rd_data : '0;

  always_comb begin
    reg_wr.ena  = dec_q.valid & dec_q.rd_w_ena;
    reg_wr.addr = dec_q.rd_w_addr;
    reg_wr.data = rd_data;
    csr_wr.ena  = dec_q.valid & dec_q.csr_wr_ena;
    csr_wr.addr = dec_q.csr_addr;
    csr_wr.data = alu_out;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= dec_q.valid;
    end
  end

  always_ff @(posedge clk) begin
    retire.pc       <= dec_q.pc;
    retire.rd_w_ena <= dec_q.rd_w_ena;
    retire.rd       <= dec_q.rd_w_addr;
    retire.result   <= result;
    retire.taken    <= taken;
    retire.target   <= taken ? target : '0;
    retire.illegal  <= dec_q.illegal;
  end

endmodule

`default_nettype wire

/* id_stage.sv */
/*
 * instruction decode: classifies the head instruction, reads operands
 * and builds the decode record for the execute stage
 */
`default_nettype none

module id_stage
  import rv_core_pkg::*;
(
  input  logic            reset,
  input  logic            issue_valid,
  input  in_item_t        issue_item,
  output logic [4:0]      rs1_addr,
  output logic [4:0]      rs2_addr,
  input  logic [XLEN-1:0] r_data1,
  input  logic [XLEN-1:0] r_data2,
  output logic [11:0]     csr_addr,
  input  logic [XLEN-1:0] csr_data,
  output dec_t            dec
);

  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_FENCE  = 7'h0f;
  localparam logic [6:0] OPC_IMM    = 7'h13;
  localparam logic [6:0] OPC_AUIPC  = 7'h17;
  localparam logic [6:0] OPC_IMM_W  = 7'h1b;
  localparam logic [6:0] OPC_STORE  = 7'h23;
  localparam logic [6:0] OPC_REG    = 7'h33;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_REG_W  = 7'h3b;
  localparam logic [6:0] OPC_BRANCH = 7'h63;
  localparam logic [6:0] OPC_JALR   = 7'h67;
  localparam logic [6:0] OPC_JAL    = 7'h6f;
  localparam logic [6:0] OPC_SYSTEM = 7'h73;
  localparam logic [6:0] OPC_PUTCH  = 7'h7b;

  inst_u           inst;
  logic            act;
  logic [6:0]      opcode;
  logic [2:0]      func3;
  logic [6:0]      func7;
  logic [7:0]      f3;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] zimm;
  logic [XLEN-1:0] rs1_lo;
  logic [XLEN-1:0] rs2_lo;

  logic op_load;
  logic op_fence;
  logic op_imm;
  logic op_auipc;
  logic op_imm_w;
  logic op_store;
  logic op_reg;
  logic op_lui;
  logic op_reg_w;
  logic op_branch;
  logic op_jalr;
  logic op_jal;
  logic op_system;
  logic op_putch;
  logic op_csr;
  logic arith;
  logic is_r;
  logic known;
  logic rs1_used;
  logic rs2_used;

  alu_info_t       alu;
  bj_info_t        bj;
  wb_sel_t         wb;
  logic [XLEN-1:0] op1;
  logic [XLEN-1:0] op2;
  logic [XLEN-1:0] jmp_imm;

  assign inst   = issue_item.inst;
  assign act    = issue_valid & ~reset;
  assign opcode = inst.r_fmt.opcode;
  assign func3  = inst.r_fmt.func3;
  assign func7  = inst.r_fmt.func7;
  assign f3     = 8'b1 << func3;

  // immediates, sign extended to XLEN
  assign imm_i = {{(XLEN-12){inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
  assign imm_s = {{(XLEN-12){inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
  assign imm_b = {{(XLEN-12){inst.b_fmt.imm_12}}, inst.b_fmt.imm_11, inst.b_fmt.imm_10_5,
                  inst.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {{(XLEN-32){inst.u_fmt.imm[19]}}, inst.u_fmt.imm, 12'b0};
  assign imm_j = {{(XLEN-20){inst.j_fmt.imm_20}}, inst.j_fmt.imm_19_12, inst.j_fmt.imm_11,
                  inst.j_fmt.imm_10_1, 1'b0};
  assign zimm  = {{(XLEN-5){1'b0}}, inst.i_fmt.rs1};

  // word ops see only the low halves
  assign rs1_lo = {{(XLEN-32){1'b0}}, r_data1[31:0]};
  assign rs2_lo = {{(XLEN-32){1'b0}}, r_data2[31:0]};

  // instruction classes, all low when nothing issues
  assign op_load   = act & (opcode == OPC_LOAD);
  assign op_fence  = act & (opcode == OPC_FENCE);
  assign op_imm    = act & (opcode == OPC_IMM);
  assign op_auipc  = act & (opcode == OPC_AUIPC);
  assign op_imm_w  = act & (opcode == OPC_IMM_W);
  assign op_store  = act & (opcode == OPC_STORE);
  assign op_reg    = act & (opcode == OPC_REG);
  assign op_lui    = act & (opcode == OPC_LUI);
  assign op_reg_w  = act & (opcode == OPC_REG_W);
  assign op_branch = act & (opcode == OPC_BRANCH);
  assign op_jalr   = act & (opcode == OPC_JALR);
  assign op_jal    = act & (opcode == OPC_JAL);
  assign op_system = act & (opcode == OPC_SYSTEM);
  assign op_putch  = act & (opcode == OPC_PUTCH);
  // ecall and ebreak have func3 zero and fall through as no-ops
  assign op_csr    = op_system & (func3[1:0] != 2'b00);

  assign arith = op_imm | op_imm_w | op_reg | op_reg_w;
  assign is_r  = op_reg | op_reg_w;
  assign known = op_load | op_fence | op_imm | op_auipc | op_imm_w | op_store | op_reg
               | op_lui | op_reg_w | op_branch | op_jalr | op_jal | op_system | op_putch;

  always_comb begin
    alu.add  = (arith & f3[0] & ~(is_r & func7[5])) | op_load | op_store | op_lui | op_auipc;
    alu.sub  = is_r & f3[0] & func7[5];
    alu.slt  = arith & f3[2];
    alu.sltu = arith & f3[3];
    alu.bxor = arith & f3[4];
    alu.bor  = (arith & f3[6]) | (op_csr & (func3[1:0] == 2'b10));
    alu.band = arith & f3[7];
    alu.sll  = arith & f3[1];
    // srai carries its 0x20 marker in the same bit as func7
    alu.srl  = arith & f3[5] & ~func7[5];
    alu.sra  = arith & f3[5] & func7[5];
    alu.andn = op_csr & (func3[1:0] == 2'b11);
    alu.wri  = op_csr & (func3[1:0] == 2'b01);
  end

  always_comb begin
    bj.beq  = op_branch & f3[0];
    bj.bne  = op_branch & f3[1];
    bj.blt  = op_branch & f3[4];
    bj.bge  = op_branch & f3[5];
    bj.bltu = op_branch & f3[6];
    bj.bgeu = op_branch & f3[7];
    bj.jalr = op_jalr;
    bj.jal  = op_jal;
  end

  always_comb begin
    wb.exe_to_reg = arith | op_lui | op_auipc;
    wb.mem_addr   = op_load | op_store;
    wb.pc_to_reg  = op_jal | op_jalr;
    wb.csr_to_reg = op_csr;
  end

  assign rs1_used = op_load | op_imm | op_imm_w | op_store | op_reg | op_reg_w | op_branch
                  | op_jalr | (op_csr & ~func3[2]);
  assign rs2_used = op_reg | op_reg_w | op_branch;

  assign rs1_addr = rs1_used ? inst.r_fmt.rs1 : 5'd0;
  assign rs2_addr = rs2_used ? inst.r_fmt.rs2 : 5'd0;
  assign csr_addr = op_csr ? inst.i_fmt.imm : 12'd0;

  always_comb begin
    op1     = '0;
    op2     = '0;
    jmp_imm = '0;
    case (1'b1)
      op_load, op_imm: begin
        op1 = r_data1;
        op2 = imm_i;
      end
      op_imm_w: begin
        op1 = rs1_lo;
        op2 = imm_i;
      end
      op_store: begin
        op1 = r_data1;
        op2 = imm_s;
      end
      op_reg: begin
        op1 = r_data1;
        op2 = r_data2;
      end
      op_reg_w: begin
        op1 = rs1_lo;
        op2 = rs2_lo;
      end
      op_branch: begin
        op1     = r_data1;
        op2     = r_data2;
        jmp_imm = imm_b;
      end
      op_lui: begin
        op2 = imm_u;
      end
      op_auipc: begin
        op1 = issue_item.pc;
        op2 = imm_u;
      end
      op_jalr: begin
        op1     = r_data1;
        jmp_imm = imm_i;
      end
      op_jal: begin
        jmp_imm = imm_j;
      end
      op_csr: begin
        op1 = csr_data;
        op2 = func3[2] ? zimm : r_data1;
      end
      default: ;
    endcase
  end

  always_comb begin
    dec.valid      = act;
    dec.pc         = issue_item.pc;
    dec.op1        = op1;
    dec.op2        = op2;
    dec.jmp_imm    = jmp_imm;
    dec.is_word    = op_imm_w | op_reg_w;
    dec.alu_info   = alu;
    dec.bj_info    = bj;
    dec.wb_sel     = wb;
    dec.rd_w_ena   = wb.exe_to_reg | wb.pc_to_reg | wb.csr_to_reg;
    dec.rd_w_addr  = dec.rd_w_ena ? inst.r_fmt.rd : 5'd0;
    dec.csr_wr_ena = op_csr;
    dec.csr_addr   = csr_addr;
    dec.csr_old    = op_csr ? csr_data : '0;
    dec.illegal    = act & ~known;
  end

endmodule

`default_nettype wire

/* inst_queue.sv */
/*
 * instruction queue: credit-fed input FIFO plus the output credit
 * counter that decides when the head item issues
 */
`default_nettype none

module inst_queue
  import rv_core_pkg::*;
#(
  parameter int QUEUE_DEPTH = 4,
  parameter int OUT_CREDITS = 2
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     in_valid,
  input  in_item_t in_item,
  output logic     in_credit,
  input  logic     out_credit,
  output logic     issue_valid,
  output in_item_t issue_item
);

  localparam int PTR_W  = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W  = $clog2(QUEUE_DEPTH + 1);
  localparam int CRED_W = $clog2(OUT_CREDITS + 1);

  in_item_t          mem [QUEUE_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic [CRED_W-1:0] credits;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // head leaves whenever there is room downstream
  assign issue_valid = (count != '0) && (credits != '0);
  assign issue_item  = mem[rd_ptr];
  assign in_credit   = issue_valid;

  always_ff @(posedge clk) begin
    if (in_valid) begin
      mem[wr_ptr] <= in_item;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      credits <= CRED_W'(OUT_CREDITS);
    end else begin
      if (in_valid) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (issue_valid) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      count   <= count + CNT_W'(in_valid) - CNT_W'(issue_valid);
      credits <= credits + CRED_W'(out_credit) - CRED_W'(issue_valid);
    end
  end

endmodule

`default_nettype wire

/* reg_file.sv */
/*
 * integer register file, x0 hardwired to zero,
 * two read ports that see a same-cycle write
 */
`default_nettype none

module reg_file
  import rv_core_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic [4:0]      rs1_addr,
  input  logic [4:0]      rs2_addr,
  output logic [XLEN-1:0] r_data1,
  output logic [XLEN-1:0] r_data2,
  input  reg_wr_t         wr
);

  logic [XLEN-1:0] regs [32];

  function automatic logic [XLEN-1:0] read_port(input logic [4:0]      addr,
                                                input logic [XLEN-1:0] stored,
                                                input reg_wr_t         w);
    if (addr == 5'd0) begin
      return '0;
    end
    if (w.ena && (w.addr == addr)) begin
      return w.data;
    end
    return stored;
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.ena && (wr.addr != 5'd0)) begin
      regs[wr.addr] <= wr.data;
    end
  end

  assign r_data1 = read_port(rs1_addr, regs[rs1_addr], wr);
  assign r_data2 = read_port(rs2_addr, regs[rs2_addr], wr);

endmodule

`default_nettype wire

/* rv_core_assert.sv */
/*
 * rv_core protocol checks on input credits, output credits and reset
 */
`default_nettype none

module rv_core_assert #(
  parameter int OUT_CREDITS = 2
) (
  input logic clk,
  input logic reset,
  input logic in_valid,
  input logic in_credit,
  input logic out_credit,
  input logic retire_valid
);

  logic [15:0] items_in;
  logic [15:0] credits_back;
  logic [7:0]  slots_used;
  int          failures = 0;

  always_ff @(posedge clk) begin
    if (reset) begin
      items_in     <= '0;
      credits_back <= '0;
      slots_used   <= '0;
    end else begin
      items_in     <= items_in + 16'(in_valid);
      credits_back <= credits_back + 16'(in_credit);
      slots_used   <= slots_used + 8'(retire_valid) - 8'(out_credit);
    end
  end

  credit_follows_item: assert property (@(posedge clk) disable iff (reset)
    in_credit |-> (credits_back < items_in))
    else begin
      $error("in_credit returned with no item queued");
      failures++;
    end

  // every returned credit is an issue that retires two cycles on
  credit_reaches_retire: assert property (@(posedge clk) disable iff (reset)
    in_credit |-> ##2 retire_valid)
    else begin
      $error("in_credit without a matching retire");
      failures++;
    end

  retire_has_slot: assert property (@(posedge clk) disable iff (reset)
    retire_valid |-> (slots_used < OUT_CREDITS))
    else begin
      $error("retire without an output credit");
      failures++;
    end

  quiet_in_reset: assert property (@(posedge clk) reset |=> !retire_valid)
    else begin
      $error("retire_valid high during reset");
      failures++;
    end

endmodule

bind rv_core_top rv_core_assert #(
  .OUT_CREDITS (OUT_CREDITS)
) u_assert (
  .clk          (clk),
  .reset        (reset),
  .in_valid     (in_valid),
  .in_credit    (in_credit),
  .out_credit   (out_credit),
  .retire_valid (retire_valid)
);

`default_nettype wire

/* rv_core_cases.txt */
// pc, instruction word, expected rd, rd write flag, result, taken, target, illegal
// one instruction per line, all fields hex, in program order
1000 fff00093 01 1 ffffffffffffffff 0 0 0
1004 12300113 02 1 0000000000000123 0 0 0
1008 002081b3 03 1 0000000000000122 0 0 0
100c 40218233 04 1 ffffffffffffffff 0 0 0
1010 002222b3 05 1 0000000000000001 0 0 0
1014 00223333 06 1 0000000000000000 0 0 0
1018 00510013 00 1 0000000000000128 0 0 0
101c 00000393 07 1 0000000000000000 0 0 0
1020 03f09413 08 1 8000000000000000 0 0 0
1024 40445493 09 1 f800000000000000 0 0 0
1028 03c45513 0a 1 0000000000000008 0 0 0
102c 800005b7 0b 1 ffffffff80000000 0 0 0
1030 fff5861b 0c 1 000000007fffffff 0 0 0
1034 00c606bb 0d 1 fffffffffffffffe 0 0 0
1038 4025d73b 0e 1 fffffffff0000000 0 0 0
103c 12345797 0f 1 000000001234603c 0 0 0
1040 00710863 00 0 0000000000000000 0 0 0
1044 fe711ce3 00 0 0000000000000000 1 103c 0
1048 00224463 00 0 0000000000000000 1 1050 0
104c 1000086f 10 1 0000000000001050 1 114c 0
1050 010108e7 11 1 0000000000001054 1 132 0
1054 34009973 12 1 0000000000000000 0 0 0
1058 340139f3 13 1 ffffffffffffffff 0 0 0
105c 3401ea73 14 1 fffffffffffffedc 0 0 0
1060 305fdaf3 15 1 0000000000000000 0 0 0
1064 34002b73 16 1 fffffffffffffedf 0 0 0
1068 30502bf3 17 1 000000000000001f 0 0 0
106c 7c009c73 18 1 0000000000000000 0 0 0
1070 00813d03 00 0 000000000000012b 0 0 0
1074 fe113823 00 0 0000000000000113 0 0 0
1078 0000002b 00 0 0000000000000000 0 0 1
107c 00000073 00 0 0000000000000000 0 0 0
1080 0044cdb3 1b 1 07ffffffffffffff 0 0 0

/* rv_core_pkg.sv */
/*
 * rv_core shared definitions: data width, RISC-V instruction formats,
 * decode, writeback and retire records, machine CSR addresses
 */
`default_nettype none

package rv_core_pkg;

  localparam int XLEN = 64;

  // machine CSRs held by csr_file
  localparam logic [11:0] CSR_MSTATUS  = 12'h300;
  localparam logic [11:0] CSR_MTVEC    = 12'h305;
  localparam logic [11:0] CSR_MSCRATCH = 12'h340;
  localparam logic [11:0] CSR_MEPC     = 12'h341;

  typedef struct packed {
    logic [6:0] func7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] func3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  func3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] func3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] func3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one instruction word, seen through each format
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } inst_u;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [31:0]     inst;
  } in_item_t;

  // one-hot ALU operation
  typedef struct packed {
    logic add;
    logic sub;
    logic slt;
    logic sltu;
    logic bxor;
    logic bor;
    logic band;
    logic sll;
    logic srl;
    logic sra;
    logic andn;
    logic wri;
  } alu_info_t;

  typedef struct packed {
    logic beq;
    logic bne;
    logic blt;
    logic bge;
    logic bltu;
    logic bgeu;
    logic jalr;
    logic jal;
  } bj_info_t;

  typedef struct packed {
    logic exe_to_reg;
    logic mem_addr;
    logic pc_to_reg;
    logic csr_to_reg;
  } wb_sel_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] jmp_imm;
    logic            is_word;
    alu_info_t       alu_info;
    bj_info_t        bj_info;
    wb_sel_t         wb_sel;
    logic            rd_w_ena;
    logic [4:0]      rd_w_addr;
    logic            csr_wr_ena;
    logic [11:0]     csr_addr;
    logic [XLEN-1:0] csr_old;
    logic            illegal;
  } dec_t;

  typedef struct packed {
    logic            ena;
    logic [4:0]      addr;
    logic [XLEN-1:0] data;
  } reg_wr_t;

  typedef struct packed {
    logic            ena;
    logic [11:0]     addr;
    logic [XLEN-1:0] data;
  } csr_wr_t;

  // target is zero unless the transfer was taken
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic            rd_w_ena;
    logic [4:0]      rd;
    logic [XLEN-1:0] result;
    logic            taken;
    logic [XLEN-1:0] target;
    logic            illegal;
  } retire_t;

endpackage

`default_nettype wire

/* rv_core_top.sv */
/*
 * rv_core top level: queue, decode, register and CSR files, execute
 */
`default_nettype none

module rv_core_top
  import rv_core_pkg::*;
#(
  parameter int QUEUE_DEPTH = 4,
  parameter int OUT_CREDITS = 2
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     in_valid,
  input  in_item_t in_item,
  output logic     in_credit,
  input  logic     out_credit,
  output logic     retire_valid,
  output retire_t  retire
);

  logic            issue_valid;
  in_item_t        issue_item;
  logic [4:0]      rs1_addr;
  logic [4:0]      rs2_addr;
  logic [XLEN-1:0] r_data1;
  logic [XLEN-1:0] r_data2;
  logic [11:0]     csr_addr;
  logic [XLEN-1:0] csr_data;
  dec_t            dec;
  reg_wr_t         reg_wr;
  csr_wr_t         csr_wr;

  inst_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) u_queue (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (in_valid),
    .in_item     (in_item),
    .in_credit   (in_credit),
    .out_credit  (out_credit),
    .issue_valid (issue_valid),
    .issue_item  (issue_item)
  );

  id_stage u_id (
    .reset       (reset),
    .issue_valid (issue_valid),
    .issue_item  (issue_item),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .r_data1     (r_data1),
    .r_data2     (r_data2),
    .csr_addr    (csr_addr),
    .csr_data    (csr_data),
    .dec         (dec)
  );

  reg_file u_regs (
    .clk      (clk),
    .reset    (reset),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .r_data1  (r_data1),
    .r_data2  (r_data2),
    .wr       (reg_wr)
  );

  csr_file u_csrs (
    .clk      (clk),
    .reset    (reset),
    .csr_addr (csr_addr),
    .csr_data (csr_data),
    .wr       (csr_wr)
  );

  ex_stage u_ex (
    .clk          (clk),
    .reset        (reset),
    .dec          (dec),
    .reg_wr       (reg_wr),
    .csr_wr       (csr_wr),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

endmodule

`default_nettype wire

/* tb_rv_core.sv */
/*
 * rv_core testbench with a credit-based producer fed from the case file,
 * an output credit model with random holds and retire record checks
 */
`default_nettype none

module tb_rv_core
  import rv_core_pkg::*;
();

  localparam int QUEUE_DEPTH = 4;
  localparam int OUT_CREDITS = 2;
  localparam int MAX_CASES   = 64;
  localparam int FIELDS      = 8;

  logic        clk;
  logic        reset;
  logic        in_valid;
  in_item_t    in_item;
  logic        in_credit;
  logic        out_credit;
  logic        retire_valid;
  retire_t     retire;

  logic [63:0] case_mem [MAX_CASES*FIELDS];
  logic [31:0] lcg_state;
  inst_u       cur_inst;
  int          cur_case;
  int          num_cases;
  int          sent;
  int          retired;
  int          in_credits;
  int          credit_pulses;
  int          owed;
  int          hold;
  int          cycles;
  int          limit;
  logic        timed_out;

  rv_core_top #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) u_dut (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (in_valid),
    .in_item      (in_item),
    .in_credit    (in_credit),
    .out_credit   (out_credit),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state >> 8;
  endfunction

  task automatic check_field(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h expected %h (case %0d, opcode %h)",
               name, got, exp, cur_case, cur_inst.r_fmt.opcode);
      $display("Test FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic compare_retire(input int idx);
    int base;
    base     = idx * FIELDS;
    cur_case = idx;
    cur_inst = case_mem[base+1][31:0];
    check_field("retire.pc", retire.pc, case_mem[base]);
    check_field("retire.rd", 64'(retire.rd), case_mem[base+2]);
    check_field("retire.rd_w_ena", 64'(retire.rd_w_ena), case_mem[base+3]);
    check_field("retire.result", retire.result, case_mem[base+4]);
    check_field("retire.taken", 64'(retire.taken), case_mem[base+5]);
    check_field("retire.target", retire.target, case_mem[base+6]);
    check_field("retire.illegal", 64'(retire.illegal), case_mem[base+7]);
  endtask

  // next item goes out while a credit is held and the random gap allows
  task automatic drive_input();
    in_valid = 1'b0;
    if (sent < num_cases && in_credits > 0 && (next_rand() % 4 != 0)) begin
      in_item.pc   = case_mem[sent*FIELDS];
      in_item.inst = case_mem[sent*FIELDS+1][31:0];
      in_valid     = 1'b1;
      sent++;
      in_credits--;
    end
  endtask

  // consumer hands slots back one at a time and sometimes holds them long
  task automatic return_credit();
    logic [31:0] r;
    out_credit = 1'b0;
    if (owed > 0) begin
      if (hold > 0) begin
        hold--;
      end else begin
        r          = next_rand();
        out_credit = 1'b1;
        owed--;
        hold = (r % 6 == 0) ? 12 + int'(r % 8) : int'(r % 3);
      end
    end
  endtask

  initial begin
    reset         = 1'b1;
    in_valid      = 1'b0;
    in_item       = '0;
    out_credit    = 1'b0;
    lcg_state     = 32'd88566;
    cur_inst      = '0;
    cur_case      = 0;
    sent          = 0;
    retired       = 0;
    in_credits    = QUEUE_DEPTH;
    credit_pulses = 0;
    owed          = 0;
    hold          = 0;
    cycles        = 0;
    timed_out     = 1'b0;
    for (int i = 0; i < MAX_CASES * FIELDS; i++) begin
      case_mem[i] = ~64'(i);
    end
    $readmemh("rv_core_cases.txt", case_mem);
    num_cases = 0;
    while (num_cases < MAX_CASES &&
           case_mem[num_cases*FIELDS] != ~64'(num_cases * FIELDS)) begin
      num_cases++;
    end
    limit = num_cases * 20 + 100;

    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    while (retired < num_cases && !timed_out) begin
      @(negedge clk);
      cycles++;
      if (u_dut.u_assert.failures != 0) begin
        $display("protocol assertion failed in cycle %0d", cycles);
        $display("Test FAILED");
        $fatal(1, "assertion failure");
      end
      if (in_credit) begin
        in_credits++;
        credit_pulses++;
      end
      if (retire_valid) begin
        compare_retire(retired);
        retired++;
        owed++;
      end
      drive_input();
      return_credit();
      if (cycles >= limit) begin
        timed_out = 1'b1;
      end
    end

    if (timed_out) begin
      $display("retirement stalled: %0d of %0d instructions retired in %0d cycles",
               retired, num_cases, cycles);
      $display("Test FAILED");
      $fatal(1, "timeout");
    end else begin
      check_field("in_credit pulses", 64'(credit_pulses), 64'(sent));
      $display("Test OK");
      $finish;
    end
  end

endmodule

`default_nettype wire
